//--- fb_display_top.f
logic/fb_pkg.sv
logic/fb_write_if.sv
logic/video_timing.sv
logic/pixel_packer.sv
logic/frame_clear.sv
logic/mem_slot_arbiter.sv
logic/display_fetch.sv
logic/fb_display_top.sv
sim/fb_display_properties.sv
sim/fb_display_tb.sv

//--- logic/display_fetch.sv
// module display_fetch with word prefetch, pixel shift register and aligned video outputs

module display_fetch #(
   parameter int H_ACTIVE = 640,
   parameter int H_TOTAL  = 800,
   parameter int V_ACTIVE = 480,
   parameter int V_TOTAL  = 525
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [$clog2(H_TOTAL)-1:0] hcount,
   input  logic [$clog2(V_TOTAL)-1:0] vcount,
   input  logic                       hsync,
   input  logic                       vsync,
   input  logic                       blank,
   input  fb_pkg::word_t              mem_rdata,
   output fb_pkg::addr_t              fetch_addr,
   output fb_pkg::pixel_t             vga_pixel,
   output logic                       vga_hsync,
   output logic                       vga_vsync,
   output logic                       vga_blank
);

   localparam int HC_W           = $clog2(H_TOTAL);
   localparam int VC_W           = $clog2(V_TOTAL);
   localparam int LANE_W         = $clog2(fb_pkg::PIXELS_PER_WORD);
   localparam int WORDS_PER_LINE = H_ACTIVE / fb_pkg::PIXELS_PER_WORD;

   logic [HC_W-1:0] col_word;
   logic [VC_W-1:0] row;
   logic            capture;
   logic            load;
   fb_pkg::word_t   fetch_word;
   fb_pkg::word_t   shift_word;

   //////////////////////////////////////////////////////////////////////
   // prefetch address
   //////////////////////////////////////////////////////////////////////

   // group for columns c..c+3 is addressed at count c-4
   // last group of the line points at the start of the next row
   always_comb begin
      if (int'(hcount) == H_TOTAL - fb_pkg::PIXELS_PER_WORD) begin
         col_word = '0;
         row      = (int'(vcount) == V_TOTAL - 1) ? '0 : vcount + 1'b1;
      end else begin
         col_word = (hcount >> LANE_W) + 1'b1;
         row      = vcount;
      end
      // outside the picture the address parks at 0
      if ((int'(col_word) < WORDS_PER_LINE) && (int'(row) < V_ACTIVE)) begin
         fetch_addr = fb_pkg::addr_t'(row) * fb_pkg::addr_t'(WORDS_PER_LINE)
                    + fb_pkg::addr_t'(col_word);
      end else begin
         fetch_addr = '0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // capture and shift
   //////////////////////////////////////////////////////////////////////

   // read issued in the fetch slot comes back two cycles later
   assign capture = (hcount[1:0] == 2'd2);
   // reload one cycle before the first column of the group
   assign load    = (hcount[1:0] == 2'd3);

   always_ff @(posedge clk) begin
      if (capture) begin
         fetch_word <= mem_rdata;
      end
      if (load) begin
         shift_word <= fetch_word;
      end else begin
         shift_word <= shift_word >> fb_pkg::PIXEL_W;
      end
   end

   // one register stage for pixel, syncs and blank together
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vga_pixel <= '0;
         vga_hsync <= 1'b0;
         vga_vsync <= 1'b0;
         vga_blank <= 1'b1;
      end else begin
         vga_pixel <= blank ? '0 : shift_word[fb_pkg::PIXEL_W-1:0];
         vga_hsync <= hsync;
         vga_vsync <= vsync;
         vga_blank <= blank;
      end
   end

endmodule

//--- logic/fb_display_top.sv
// module fb_display_top connecting timing, camera packer, clear sweep, slot arbiter and display

module fb_display_top #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_TOTAL  = 800,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_TOTAL  = 525
) (
   input  logic           clk,
   input  logic           rst_n,
   // camera stream
   input  logic           cam_frame_start,
   input  logic           cam_valid,
   input  fb_pkg::pixel_t cam_pixel,
   // clear control
   input  logic           clear_start,
   output logic           clear_busy,
   // memory port
   output fb_pkg::addr_t  mem_addr,
   output fb_pkg::word_t  mem_wdata,
   output logic           mem_we,
   input  fb_pkg::word_t  mem_rdata,
   // video out
   output fb_pkg::pixel_t vga_pixel,
   output logic           vga_hsync,
   output logic           vga_vsync,
   output logic           vga_blank
);

   localparam int HC_W = $clog2(H_TOTAL);
   localparam int VC_W = $clog2(V_TOTAL);

   logic [HC_W-1:0] hcount;
   logic [VC_W-1:0] vcount;
   logic            hsync;
   logic            vsync;
   logic            blank;
   fb_pkg::addr_t   fetch_addr;

   // write requesters
   fb_write_if clear_wr ();
   fb_write_if cam_wr ();

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
   ) video_timing_inst (
      .clk(clk), .rst_n(rst_n),
      .hcount(hcount), .vcount(vcount),
      .hsync(hsync), .vsync(vsync), .blank(blank)
   );

   pixel_packer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) pixel_packer_inst (
      .clk(clk), .rst_n(rst_n),
      .cam_frame_start(cam_frame_start), .cam_valid(cam_valid), .cam_pixel(cam_pixel),
      .clear_busy(clear_busy), .wr(cam_wr.requester)
   );

   frame_clear #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) frame_clear_inst (
      .clk(clk), .rst_n(rst_n),
      .clear_start(clear_start), .blank(blank),
      .clear_busy(clear_busy), .wr(clear_wr.requester)
   );

   mem_slot_arbiter #(.H_TOTAL(H_TOTAL)) mem_slot_arbiter_inst (
      .clk(clk), .rst_n(rst_n), .hcount(hcount),
      .clear_wr(clear_wr.arbiter), .cam_wr(cam_wr.arbiter),
      .fetch_addr(fetch_addr),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we)
   );

   display_fetch #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
   ) display_fetch_inst (
      .clk(clk), .rst_n(rst_n),
      .hcount(hcount), .vcount(vcount),
      .hsync(hsync), .vsync(vsync), .blank(blank),
      .mem_rdata(mem_rdata), .fetch_addr(fetch_addr),
      .vga_pixel(vga_pixel), .vga_hsync(vga_hsync),
      .vga_vsync(vga_vsync), .vga_blank(vga_blank)
   );

endmodule

//--- logic/fb_pkg.sv
// frame buffer package with pixel, word and address widths, their types, slot and clear enums

package fb_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////

   // one grey level per pixel
   localparam int PIXEL_W = 8;
   // memory word holds a group of four pixels
   localparam int WORD_W = 32;
   localparam int PIXELS_PER_WORD = WORD_W / PIXEL_W;
   // word address into the frame memory
   localparam int ADDR_W = 19;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   typedef logic [PIXEL_W-1:0] pixel_t;
   // pixel 0 of the group sits in bits 7:0
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // four cycle memory slot, taken from hcount[1:0]
   typedef enum logic [1:0] {
      SLOT_FETCH  = 2'd0,
      SLOT_SPARE1 = 2'd1,
      SLOT_WRITE  = 2'd2,
      SLOT_SPARE3 = 2'd3
   } mem_slot_e;

   // clear sweep state
   typedef enum logic {
      CLEAR_IDLE,
      CLEAR_SWEEP
   } clear_state_e;

endpackage

//--- logic/fb_write_if.sv
// interface fb_write_if for one write requester and the memory slot arbiter

interface fb_write_if;

   // request level, held until taken
   logic          req;
   fb_pkg::addr_t addr;
   fb_pkg::word_t data;
   // single cycle, high in the write slot that commits the word
   logic          taken;

   modport requester (
      output req, addr, data,
      input  taken
   );

   modport arbiter (
      input  req, addr, data,
      output taken
   );

endinterface

//--- logic/frame_clear.sv
// module frame_clear with a zero write sweep over all word addresses during blanking

module frame_clear #(
   parameter int H_ACTIVE = 640,
   parameter int V_ACTIVE = 480
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          clear_start,
   input  logic          blank,
   output logic          clear_busy,
   fb_write_if.requester wr
);

   localparam int WORD_COUNT = (H_ACTIVE / fb_pkg::PIXELS_PER_WORD) * V_ACTIVE;
   localparam fb_pkg::addr_t LAST_ADDR = fb_pkg::addr_t'(WORD_COUNT - 1);

   fb_pkg::clear_state_e state;
   fb_pkg::addr_t        clear_addr;

   // sweep FSM
   // a start pulse restarts the sweep from word 0 in any state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= fb_pkg::CLEAR_IDLE;
         clear_addr <= '0;
      end else begin
         if (clear_start) begin
            state      <= fb_pkg::CLEAR_SWEEP;
            clear_addr <= '0;
         end else if ((state == fb_pkg::CLEAR_SWEEP) && wr.taken) begin
            // last word written, back to idle
            if (clear_addr == LAST_ADDR) begin
               state <= fb_pkg::CLEAR_IDLE;
            end else begin
               clear_addr <= clear_addr + 1'b1;
            end
         end
      end
   end

   assign clear_busy = (state == fb_pkg::CLEAR_SWEEP);

   // writes only go out while the screen is blanked
   // so the display never reads a half cleared line
   assign wr.req  = (state == fb_pkg::CLEAR_SWEEP) && blank;
   assign wr.addr = clear_addr;
   assign wr.data = '0;

endmodule

//--- logic/mem_slot_arbiter.sv
// module mem_slot_arbiter that decodes the memory slot and drives the shared memory port

module mem_slot_arbiter #(
   parameter int H_TOTAL = 800
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [$clog2(H_TOTAL)-1:0] hcount,
   fb_write_if.arbiter                clear_wr,
   fb_write_if.arbiter                cam_wr,
   input  fb_pkg::addr_t              fetch_addr,
   output fb_pkg::addr_t              mem_addr,
   output fb_pkg::word_t              mem_wdata,
   output logic                       mem_we
);

   fb_pkg::mem_slot_e slot_q;

   // slot decoded one cycle early from hcount
   // line length is a multiple of 4 so the low bits just step by one
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_q <= fb_pkg::SLOT_FETCH;
      end else begin
         slot_q <= fb_pkg::mem_slot_e'(hcount[1:0] + 2'd1);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // port mux
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      clear_wr.taken = 1'b0;
      cam_wr.taken   = 1'b0;
      mem_we         = 1'b0;
      mem_addr       = fetch_addr;
      mem_wdata      = '0;
      if (slot_q == fb_pkg::SLOT_WRITE) begin
         // fixed priority, clear before camera
         if (clear_wr.req) begin
            clear_wr.taken = 1'b1;
            mem_we         = 1'b1;
            mem_addr       = clear_wr.addr;
            mem_wdata      = clear_wr.data;
         end else if (cam_wr.req) begin
            cam_wr.taken = 1'b1;
            mem_we       = 1'b1;
            mem_addr     = cam_wr.addr;
            mem_wdata    = cam_wr.data;
         end
      end
   end

endmodule

//--- logic/pixel_packer.sv
// module pixel_packer that groups camera pixels into words and holds one pending write

module pixel_packer #(
   parameter int H_ACTIVE = 640,
   parameter int V_ACTIVE = 480
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           cam_frame_start,
   input  logic           cam_valid,
   input  fb_pkg::pixel_t cam_pixel,
   input  logic           clear_busy,
   fb_write_if.requester  wr
);

   localparam int WORD_COUNT = (H_ACTIVE / fb_pkg::PIXELS_PER_WORD) * V_ACTIVE;
   localparam int LANE_W     = $clog2(fb_pkg::PIXELS_PER_WORD);
   localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(fb_pkg::PIXELS_PER_WORD - 1);
   localparam fb_pkg::addr_t LAST_ADDR = fb_pkg::addr_t'(WORD_COUNT - 1);

   fb_pkg::word_t     asm_word;
   fb_pkg::word_t     next_word;
   fb_pkg::addr_t     word_addr;
   logic [LANE_W-1:0] lane;
   logic              armed;
   logic              accept;
   logic              word_done;

   // pixels count only inside a frame that started with no clear running
   assign accept    = cam_valid && armed && !clear_busy && !cam_frame_start;
   assign word_done = accept && (lane == LAST_LANE);
   // new pixel enters at the top, first pixel ends up in the low byte
   assign next_word = {cam_pixel, asm_word[fb_pkg::WORD_W-1:fb_pkg::PIXEL_W]};

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         armed     <= 1'b0;
         lane      <= '0;
         word_addr <= '0;
         wr.req    <= 1'b0;
      end else begin
         // a clear drops the frame, assembly waits for the next start
         if (clear_busy) begin
            armed <= 1'b0;
         end else if (cam_frame_start) begin
            armed <= 1'b1;
         end
         if (cam_frame_start) begin
            lane      <= '0;
            word_addr <= '0;
         end else if (accept) begin
            lane <= lane + 1'b1;
            if (word_done) begin
               word_addr <= (word_addr == LAST_ADDR) ? '0 : word_addr + 1'b1;
            end
         end
         // a finished word wins over the taken of the previous one
         if (word_done) begin
            wr.req <= 1'b1;
         end else if (wr.taken) begin
            wr.req <= 1'b0;
         end
      end
   end

   // assembly and pending word
   always_ff @(posedge clk) begin
      if (accept) begin
         asm_word <= next_word;
      end
      if (word_done) begin
         wr.data <= next_word;
         wr.addr <= word_addr;
      end
   end

endmodule

//--- logic/video_timing.sv
// module video_timing with free running line and frame counters, registered sync and blank

module video_timing #(
   parameter int H_ACTIVE = 640,
   parameter int H_FRONT  = 16,
   parameter int H_SYNC   = 96,
   parameter int H_TOTAL  = 800,
   parameter int V_ACTIVE = 480,
   parameter int V_FRONT  = 10,
   parameter int V_SYNC   = 2,
   parameter int V_TOTAL  = 525
) (
   input  logic                       clk,
   input  logic                       rst_n,
   output logic [$clog2(H_TOTAL)-1:0] hcount,
   output logic [$clog2(V_TOTAL)-1:0] vcount,
   output logic                       hsync,
   output logic                       vsync,
   output logic                       blank
);

   localparam int HC_W = $clog2(H_TOTAL);
   localparam int VC_W = $clog2(V_TOTAL);
   // sync windows, counted from the start of the line or frame
   localparam int HS_START = H_ACTIVE + H_FRONT;
   localparam int HS_END   = HS_START + H_SYNC;
   localparam int VS_START = V_ACTIVE + V_FRONT;
   localparam int VS_END   = VS_START + V_SYNC;

   logic [HC_W-1:0] h_next;
   logic [VC_W-1:0] v_next;

   // next count, line wrap steps the line counter
   always_comb begin
      h_next = hcount + 1'b1;
      v_next = vcount;
      if (int'(hcount) == H_TOTAL - 1) begin
         h_next = '0;
         v_next = (int'(vcount) == V_TOTAL - 1) ? '0 : vcount + 1'b1;
      end
   end

   // sync and blank decoded from the next count
   // so that they line up with hcount and vcount
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         blank  <= 1'b0;
      end else begin
         hcount <= h_next;
         vcount <= v_next;
         hsync  <= (int'(h_next) >= HS_START) && (int'(h_next) < HS_END);
         vsync  <= (int'(v_next) >= VS_START) && (int'(v_next) < VS_END);
         blank  <= (int'(h_next) >= H_ACTIVE) || (int'(v_next) >= V_ACTIVE);
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the frame buffer testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f fb_display_top.f \
   --top-module fb_display_tb -o fb_display_sim > build.log 2>&1 \
   && ./obj_dir/fb_display_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
exit 0

//--- sim/fb_display_properties.sv
// module fb_display_properties with slot, clear and grant assertions, and its bind to the top level

module fb_display_properties (
   input logic       clk,
   input logic       rst_n,
   input logic [1:0] slot_bits,
   input logic       mem_we,
   input logic       blank,
   input logic       clear_taken,
   input logic       cam_taken
);

   timeunit 1ns;
   timeprecision 1ps;

   // memory writes only in the write slot of the four cycle period
   assert property (@(posedge clk) disable iff (!rst_n)
      mem_we |-> (fb_pkg::mem_slot_e'(slot_bits) == fb_pkg::SLOT_WRITE))
      else $error("memory write outside the write slot");

   // clear writes stay inside blanking
   assert property (@(posedge clk) disable iff (!rst_n)
      clear_taken |-> blank)
      else $error("clear write while the display is active");

   // one grant per slot
   assert property (@(posedge clk) disable iff (!rst_n)
      !(clear_taken && cam_taken))
      else $error("both write requesters granted in one cycle");

endmodule

// slot is the low bits of hcount, same as the arbiter's registered slot
bind fb_display_top fb_display_properties fb_display_properties_inst (
   .clk(clk),
   .rst_n(rst_n),
   .slot_bits(hcount[1:0]),
   .mem_we(mem_we),
   .blank(blank),
   .clear_taken(clear_wr.taken),
   .cam_taken(cam_wr.taken)
);

//--- sim/fb_display_tb.sv
// module fb_display_tb with clock, reset, memory model and directed frame buffer tests

module fb_display_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int H_ACTIVE = 16;
   localparam int H_FRONT  = 2;
   localparam int H_SYNC   = 2;
   localparam int H_TOTAL  = 24;
   localparam int V_ACTIVE = 8;
   localparam int V_FRONT  = 1;
   localparam int V_SYNC   = 2;
   localparam int V_TOTAL  = 12;
   localparam int WPL      = H_ACTIVE / 4;
   localparam int WORDS    = WPL * V_ACTIVE;
   localparam int FRAME    = H_TOTAL * V_TOTAL;

   logic           clk;
   logic           rst_n;
   logic           cam_frame_start;
   logic           cam_valid;
   fb_pkg::pixel_t cam_pixel;
   logic           clear_start;
   logic           clear_busy;
   fb_pkg::addr_t  mem_addr;
   fb_pkg::word_t  mem_wdata;
   logic           mem_we;
   fb_pkg::word_t  mem_rdata;
   fb_pkg::pixel_t vga_pixel;
   logic           vga_hsync;
   logic           vga_vsync;
   logic           vga_blank;

   int errors = 0;
   int checks = 0;
   int write_count = 0;

   //////////////////////////////////////////////////////////////////////
   // memory model
   //////////////////////////////////////////////////////////////////////

   fb_pkg::word_t mem [0:WORDS-1];
   fb_pkg::word_t rd_pipe;
   logic          fill_toggle = 1'b0;
   logic          fill_seen = 1'b0;

   // two stage read pipe, write commits on the edge that sees mem_we
   // a toggle of fill_toggle refills every word with random bytes
   always @(posedge clk) begin
      if (fill_toggle != fill_seen) begin
         fill_seen <= fill_toggle;
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= $urandom;
         end
      end else if (mem_we && (int'(mem_addr) < WORDS)) begin
         mem[int'(mem_addr)] <= mem_wdata;
      end
      rd_pipe   <= (int'(mem_addr) < WORDS) ? mem[int'(mem_addr)] : '0;
      mem_rdata <= rd_pipe;
   end

   // writes seen mid cycle
   always @(negedge clk) begin
      if (rst_n && mem_we) begin
         write_count++;
      end
   end

   fb_display_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
   ) fb_display_top_inst (
      .clk(clk), .rst_n(rst_n),
      .cam_frame_start(cam_frame_start), .cam_valid(cam_valid), .cam_pixel(cam_pixel),
      .clear_start(clear_start), .clear_busy(clear_busy),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata),
      .vga_pixel(vga_pixel), .vga_hsync(vga_hsync),
      .vga_vsync(vga_vsync), .vga_blank(vga_blank)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   // step to just after the next rising edge
   task automatic drive_cycle;
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   task automatic pulse_clear;
      drive_cycle();
      clear_start = 1'b1;
      drive_cycle();
      clear_start = 1'b0;
   endtask

   // outputs held in reset
   task automatic check_reset_state;
      check_value("clear_busy in reset", 32'(clear_busy), 0);
      check_value("mem_we in reset", 32'(mem_we), 0);
      check_value("vga_hsync in reset", 32'(vga_hsync), 0);
      check_value("vga_vsync in reset", 32'(vga_vsync), 0);
      check_value("vga_blank in reset", 32'(vga_blank), 1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   // line length, lines per frame, active width and active lines
   task automatic test_timing;
      int  last_h;
      int  h_rises;
      int  last_v_line;
      int  fall_at;
      int  blank_rose;
      int  act_lines;
      int  measured;
      logic ph;
      logic pv;
      logic pb;
      last_h      = -1;
      h_rises     = 0;
      last_v_line = -1;
      fall_at     = -1;
      blank_rose  = -1;
      act_lines   = 0;
      measured    = 0;
      @(negedge clk);
      ph = vga_hsync;
      pv = vga_vsync;
      pb = vga_blank;
      for (int cyc = 0; cyc < 3 * FRAME; cyc++) begin
         @(negedge clk);
         if (vga_hsync && !ph) begin
            if (last_h >= 0) begin
               check_value("cycles per line", cyc - last_h, H_TOTAL);
            end
            // front porch only on lines that had an active run
            if ((blank_rose >= 0) && (cyc - blank_rose < H_TOTAL)) begin
               check_value("hsync front porch", cyc - blank_rose, H_FRONT);
            end
            last_h = cyc;
            h_rises++;
         end
         if (!vga_hsync && ph && (last_h >= 0)) begin
            check_value("hsync width", cyc - last_h, H_SYNC);
         end
         if (vga_vsync && !pv) begin
            if (last_v_line >= 0) begin
               check_value("lines per frame", h_rises - last_v_line, V_TOTAL);
               check_value("active lines", act_lines, V_ACTIVE);
               measured++;
            end
            last_v_line = h_rises;
            act_lines   = 0;
         end
         if (!vga_vsync && pv && (last_v_line >= 0)) begin
            check_value("vsync width in lines", h_rises - last_v_line, V_SYNC);
         end
         // active run of a line from blank falling to blank rising
         if (!vga_blank && pb) begin
            fall_at = cyc;
            act_lines++;
         end
         if (vga_blank && !pb) begin
            if (fall_at >= 0) begin
               check_value("active cycles per line", cyc - fall_at, H_ACTIVE);
            end
            blank_rose = cyc;
         end
         ph = vga_hsync;
         pv = vga_vsync;
         pb = vga_blank;
      end
      if (measured == 0) begin
         report_failure("no complete frame seen in the timing test");
      end
   endtask

   // every word zeroed once, each zero write inside blanking
   task automatic test_clear;
      int  written [0:WORDS-1];
      int  t;
      bit  pend;
      bit  done;
      foreach (written[i]) written[i] = 0;
      pulse_clear();
      if (!clear_busy) begin
         report_failure("clear_busy did not rise after clear_start");
      end
      pend = 1'b0;
      done = 1'b0;
      t    = 0;
      while (!done && (t < 4 * FRAME)) begin
         @(negedge clk);
         t++;
         // blank of the write cycle shows up one cycle later
         if (pend) begin
            check_value("vga_blank after clear write", 32'(vga_blank), 1);
            pend = 1'b0;
         end
         if (!clear_busy) begin
            done = 1'b1;
         end else if (mem_we) begin
            check_value("mem_wdata of clear write", mem_wdata, 0);
            if (int'(mem_addr) < WORDS) begin
               written[int'(mem_addr)]++;
            end else begin
               report_failure("clear write outside the frame");
            end
            pend = 1'b1;
         end
      end
      if (!done) begin
         report_failure("timeout waiting for clear_busy to fall");
      end
      foreach (written[i]) begin
         check_value($sformatf("clear writes to word %0d", i), written[i], 1);
      end
   endtask

   // full frame of random pixels with gaps, then compare words
   task automatic test_camera;
      fb_pkg::pixel_t pix [0:4*WORDS-1];
      fb_pkg::word_t  exp;
      int             base;
      int             t;
      base = write_count;
      drive_cycle();
      cam_frame_start = 1'b1;
      drive_cycle();
      cam_frame_start = 1'b0;
      for (int i = 0; i < 4 * WORDS; i++) begin
         pix[i]    = fb_pkg::pixel_t'($urandom);
         cam_valid = 1'b1;
         cam_pixel = pix[i];
         drive_cycle();
         cam_valid = 1'b0;
         repeat ($urandom % 3) drive_cycle();
      end
      t = 0;
      while ((write_count - base < WORDS) && (t < 200)) begin
         @(negedge clk);
         t++;
      end
      if (write_count - base < WORDS) begin
         report_failure("timeout waiting for camera words to be written");
      end
      drive_cycle();
      for (int k = 0; k < WORDS; k++) begin
         exp = {pix[4*k+3], pix[4*k+2], pix[4*k+1], pix[4*k]};
         check_value($sformatf("mem word %0d", k), mem[k], exp);
      end
   endtask

   // output pixel against the stored byte for the counted column and row
   task automatic test_display;
      int   row;
      int   col;
      bit   new_frame;
      bit   valid;
      logic pb;
      logic pv;
      int   shown;
      fb_pkg::word_t w;
      fill_toggle = ~fill_toggle;
      drive_cycle();
      valid     = 1'b0;
      new_frame = 1'b0;
      row       = 0;
      col       = 0;
      shown     = 0;
      @(negedge clk);
      pb = vga_blank;
      pv = vga_vsync;
      for (int cyc = 0; cyc < 3 * FRAME; cyc++) begin
         @(negedge clk);
         if (vga_vsync && !pv) begin
            new_frame = 1'b1;
            valid     = 1'b1;
         end
         if (!vga_blank && pb) begin
            row       = new_frame ? 0 : row + 1;
            new_frame = 1'b0;
            col       = 0;
         end
         // pixel data is forced to zero in blanking
         if (vga_blank) begin
            check_value("vga_pixel while blanked", 32'(vga_pixel), 0);
         end else if (valid) begin
            w = mem[row * WPL + col / 4];
            check_value($sformatf("vga_pixel row %0d col %0d", row, col),
                        32'(vga_pixel), 32'(w[8*(col%4) +: 8]));
            col++;
            shown++;
         end
         pb = vga_blank;
         pv = vga_vsync;
      end
      if (shown < H_ACTIVE * V_ACTIVE) begin
         report_failure("display test saw less than one full frame");
      end
   endtask

   // pixels during a clear are dropped, memory ends all zero
   task automatic test_discard;
      int t;
      pulse_clear();
      cam_frame_start = 1'b1;
      drive_cycle();
      cam_frame_start = 1'b0;
      t = 0;
      while (clear_busy && (t < 4 * FRAME)) begin
         cam_valid = 1'b1;
         cam_pixel = fb_pkg::pixel_t'($urandom);
         drive_cycle();
         t++;
      end
      cam_valid = 1'b0;
      if (clear_busy) begin
         report_failure("timeout waiting for clear_busy to fall during discard");
      end
      repeat (2 * H_TOTAL) drive_cycle();
      for (int k = 0; k < WORDS; k++) begin
         check_value($sformatf("mem word %0d after discard", k), mem[k], 0);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(82));
      rst_n           = 1'b0;
      cam_frame_start = 1'b0;
      cam_valid       = 1'b0;
      cam_pixel       = '0;
      clear_start     = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      check_reset_state();
      rst_n = 1'b1;
      test_timing();
      test_clear();
      test_camera();
      test_display();
      test_discard();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
